// File: rtl/vdp_color_out.sv
// vdp rgb output stage
// host-written 16-entry palette and conversion of each resolved dot
// to 6-bit red, green and blue, with a valid/ready output register
`timescale 1ns/100ps
`default_nettype none

module vdp_color_out import vdp_color_pkg::*; (
    input  wire logic       CLK21M,
    input  wire logic       RESET,
    input  wire logic       pal_we,
    input  wire pal_idx_t   pal_addr,
    input  wire pal_entry_t pal_data,
    input  wire logic       head_valid,
    input  wire dot_item_t  head_item,
    output logic            pop,
    output logic            pix_valid,
    output rgb_t            pix_rgb,
    input  wire logic       pix_ready
);

    typedef enum logic {
        OUT_EMPTY = 1'b0,
        OUT_FULL  = 1'b1
    } out_state_t;

    out_state_t state;
    out_state_t state_nxt;
    pal_entry_t pal_regs [16];
    pal_entry_t pal_rd;
    logic       out_free;
    rgb_t       rgb_nxt;

    // palette registers, host write port
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            for (int i = 0; i < 16; i++) begin
                pal_regs[i] <= '0;
            end
        end else if (pal_we) begin
            pal_regs[pal_addr] <= pal_data;
        end
    end

    assign pal_rd = pal_regs[head_item.pal_idx];

    // expand to 6 bits, low three bits stay zero
    always_comb begin
        if (head_item.is_direct) begin
            // blue has only two bits, msb repeated
            rgb_nxt.r = {head_item.direct[4:2], 3'b000};
            rgb_nxt.g = {head_item.direct[7:5], 3'b000};
            rgb_nxt.b = {head_item.direct[1:0], head_item.direct[1], 3'b000};
        end else begin
            rgb_nxt.r = {pal_rd[8:6], 3'b000};
            rgb_nxt.g = {pal_rd[5:3], 3'b000};
            rgb_nxt.b = {pal_rd[2:0], 3'b000};
        end
    end

    // output register free when empty or draining this cycle
    assign pix_valid = (state == OUT_FULL);
    assign out_free  = ~pix_valid | pix_ready;
    assign pop       = head_valid & out_free;

    always_comb begin
        state_nxt = state;
        case (state)
            OUT_EMPTY: begin
                if (pop) begin
                    state_nxt = OUT_FULL;
                end
            end
            OUT_FULL: begin
                // refill on the same edge as the handoff
                if (pix_ready && !pop) begin
                    state_nxt = OUT_EMPTY;
                end
            end
            default: state_nxt = OUT_EMPTY;
        endcase
    end

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            state <= OUT_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    // pixel holds while stalled, loads only on pop
    always_ff @(posedge CLK21M) begin
        if (pop) begin
            pix_rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vdp_color_pkg.sv
// vdp color output stage, shared types
// display mode encoding, color vectors and the structs that carry
// dots and pixels between the resolver, the dot fifo and the rgb stage
`default_nettype none

package vdp_color_pkg;

    // screen modes kept by this stage
    typedef enum logic [1:0] {
        MODE_TEXT       = 2'd0,
        MODE_GRAPHIC123 = 2'd1,
        MODE_GRAPHIC46  = 2'd2,
        MODE_GRAPHIC7   = 2'd3
    } display_mode_t;

    // 16-color palette index
    typedef logic [3:0] pal_idx_t;

    // graphic-7 direct color, ggg_rrr_bb
    typedef logic [7:0] grb8_t;

    // palette entry, rrr_ggg_bbb
    typedef logic [8:0] pal_entry_t;

    // one 6-bit video channel
    typedef logic [5:0] chan6_t;

    // dot as it arrives from the pattern and sprite engines
    typedef struct packed {
        grb8_t    pattern_code;  // g4567 code, low nibble for other modes
        pal_idx_t sprite_code;
        logic     sprite_on;
        logic     window;        // inside the active display area
    } dot_in_t;

    // resolved dot, either a palette lookup or a direct color
    typedef struct packed {
        logic     is_direct;
        pal_idx_t pal_idx;
        grb8_t    direct;
    } dot_item_t;

    // final pixel
    typedef struct packed {
        chan6_t r;
        chan6_t g;
        chan6_t b;
    } rgb_t;

endpackage

`default_nettype wire

// File: rtl/vdp_color_top.sv
// vdp color output stage, top level
// dot resolver, credit-controlled dot fifo and palette/rgb stage
`timescale 1ns/100ps
`default_nettype none

module vdp_color_top import vdp_color_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic          CLK21M,
    input  wire logic          RESET,
    // static registers
    input  wire display_mode_t mode,
    input  wire logic          reg_disp_on,
    input  wire logic          reg_col0_on,
    input  wire grb8_t         reg_frame_col,
    // host palette write
    input  wire logic          pal_we,
    input  wire pal_idx_t      pal_addr,
    input  wire pal_entry_t    pal_data,
    // dot input
    input  wire logic          dot_valid,
    output logic               dot_ready,
    input  wire dot_in_t       dot,
    // pixel output
    output logic               pix_valid,
    output rgb_t               pix_rgb,
    input  wire logic          pix_ready
);

    logic      push;
    dot_item_t push_item;
    logic      credit_ret;
    logic      head_valid;
    dot_item_t head_item;
    logic      pop;

    vdp_dot_resolve #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_resolve (
        .CLK21M        (CLK21M),
        .RESET         (RESET),
        .mode          (mode),
        .reg_disp_on   (reg_disp_on),
        .reg_col0_on   (reg_col0_on),
        .reg_frame_col (reg_frame_col),
        .dot_valid     (dot_valid),
        .dot_ready     (dot_ready),
        .dot           (dot),
        .credit_ret    (credit_ret),
        .push          (push),
        .push_item     (push_item)
    );

    vdp_dot_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLK21M     (CLK21M),
        .RESET      (RESET),
        .push       (push),
        .push_item  (push_item),
        .pop        (pop),
        .head_valid (head_valid),
        .head_item  (head_item),
        .credit_ret (credit_ret)
    );

    vdp_color_out u_color_out (
        .CLK21M     (CLK21M),
        .RESET      (RESET),
        .pal_we     (pal_we),
        .pal_addr   (pal_addr),
        .pal_data   (pal_data),
        .head_valid (head_valid),
        .head_item  (head_item),
        .pop        (pop),
        .pix_valid  (pix_valid),
        .pix_rgb    (pix_rgb),
        .pix_ready  (pix_ready)
    );

endmodule

`default_nettype wire

// File: rtl/vdp_dot_fifo.sv
// vdp resolved dot fifo
// circular buffer between resolver and rgb stage, returns a credit
// to the resolver one cycle after each pop
`timescale 1ns/100ps
`default_nettype none

module vdp_dot_fifo import vdp_color_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic      CLK21M,
    input  wire logic      RESET,
    input  wire logic      push,
    input  wire dot_item_t push_item,
    input  wire logic      pop,
    output logic           head_valid,
    output dot_item_t      head_item,
    output logic           credit_ret
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    dot_item_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // consumer pops only a valid head
    assign head_valid = (count != '0);
    assign head_item  = mem[rd_ptr];

    // storage, credits keep push away from a full buffer
    always_ff @(posedge CLK21M) begin
        if (push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // pointers wrap at depth, works for any depth
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per popped entry
            credit_ret <= pop;
        end
    end

endmodule

`default_nettype wire

// File: rtl/vdp_dot_resolve.sv
// vdp dot resolver
// picks foreground, sprite, border or transparent color for each dot
// and sends the result to the dot fifo, spending one credit per dot
`timescale 1ns/100ps
`default_nettype none

module vdp_dot_resolve import vdp_color_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic          CLK21M,
    input  wire logic          RESET,
    input  wire display_mode_t mode,
    input  wire logic          reg_disp_on,
    input  wire logic          reg_col0_on,
    input  wire grb8_t         reg_frame_col,
    input  wire logic          dot_valid,
    output logic               dot_ready,
    input  wire dot_in_t       dot,
    input  wire logic          credit_ret,
    output logic               push,
    output dot_item_t          push_item
);

    localparam int CRD_W = $clog2(FIFO_DEPTH + 1);

    logic [CRD_W-1:0] credits;
    logic             accept;
    logic             show_back;
    pal_idx_t         fore_color;
    grb8_t            spr_grb;
    dot_item_t        resolved;

    // a free fifo slot exists for every credit held
    assign dot_ready = (credits != '0);
    assign accept    = dot_valid & dot_ready;

    // border when outside the window or with the screen blanked
    assign show_back = ~dot.window | ~reg_disp_on;

    // sprites never show in text modes
    assign fore_color = (dot.sprite_on && mode != MODE_TEXT) ?
                        dot.sprite_code : dot.pattern_code[3:0];

    // graphic-7 sprite table
    always_comb begin
        logic [2:0] lvl3;
        logic [1:0] lvl2;
        lvl3 = dot.sprite_code[3] ? 3'b111 : 3'b011;
        lvl2 = dot.sprite_code[3] ? 2'b11 : 2'b01;
        if (dot.sprite_code == 4'd0) begin
            spr_grb = 8'h00;
        end else if (dot.sprite_code == 4'd8) begin
            // odd one out, orange-ish
            spr_grb = {3'b100, 3'b111, 2'b01};
        end else begin
            spr_grb = {dot.sprite_code[2] ? lvl3 : 3'b000,
                       dot.sprite_code[1] ? lvl3 : 3'b000,
                       dot.sprite_code[0] ? lvl2 : 2'b00};
        end
    end

    always_comb begin
        resolved = '0;
        if (mode == MODE_GRAPHIC7) begin
            // direct color path
            resolved.is_direct = 1'b1;
            if (show_back) begin
                resolved.direct = reg_frame_col;
            end else if (dot.sprite_on) begin
                resolved.direct = spr_grb;
            end else begin
                resolved.direct = dot.pattern_code;
            end
        end else begin
            // palette path, color 0 is see-through unless col0 is set
            resolved.is_direct = 1'b0;
            if (show_back || (fore_color == 4'd0 && !reg_col0_on)) begin
                resolved.pal_idx = reg_frame_col[3:0];
            end else begin
                resolved.pal_idx = fore_color;
            end
        end
    end

    // credit counter, spend and return can coincide
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            credits <= CRD_W'(FIFO_DEPTH);
        end else begin
            case ({accept, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // push strobe one cycle after accept
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            push <= 1'b0;
        end else begin
            push <= accept;
        end
    end

    // payload register
    always_ff @(posedge CLK21M) begin
        if (accept) begin
            push_item <= resolved;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the vdp color testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_vdp_color \
    -f vdp_color.f \
    -Mdir obj_dir

# exit status follows the testbench result
./obj_dir/Vtb_vdp_color

// File: sim/vdp_color_model.svh
// reference model for the vdp color output stage
// dot resolution, graphic-7 sprite colors and 6-bit rgb expansion
`ifndef VDP_COLOR_MODEL_SVH
`define VDP_COLOR_MODEL_SVH

// host palette, mirrors every write the testbench makes
pal_entry_t model_pal [16];

// fixed graphic-7 sprite colors, ggg_rrr_bb
function automatic grb8_t model_sprite_grb(input pal_idx_t c);
    logic [2:0] lvl_gr;
    logic [1:0] lvl_b;
    // bit 3 selects bright over dim
    lvl_gr = c[3] ? 3'd7 : 3'd3;
    lvl_b  = c[3] ? 2'd3 : 2'd1;
    if (c == 4'd0) begin
        return 8'h00;
    end
    if (c == 4'd8) begin
        return 8'b100_111_01;
    end
    return {(c[2] ? lvl_gr : 3'd0), (c[1] ? lvl_gr : 3'd0), (c[0] ? lvl_b : 2'd0)};
endfunction

// palette index or direct color for one dot
function automatic dot_item_t model_resolve(input display_mode_t m, input logic disp_on,
                                            input logic col0_on, input grb8_t frame,
                                            input dot_in_t d);
    dot_item_t it;
    pal_idx_t  fg;
    logic      border;
    it     = '0;
    border = !d.window || !disp_on;
    if (m == MODE_GRAPHIC7) begin
        it.is_direct = 1'b1;
        if (border) begin
            it.direct = frame;
        end else if (d.sprite_on) begin
            it.direct = model_sprite_grb(d.sprite_code);
        end else begin
            it.direct = d.pattern_code;
        end
        return it;
    end
    // no sprites in text mode
    fg = (d.sprite_on && m != MODE_TEXT) ? d.sprite_code : d.pattern_code[3:0];
    // color 0 shows the border unless col0 is set
    it.pal_idx = (border || (fg == 4'd0 && !col0_on)) ? frame[3:0] : fg;
    return it;
endfunction

// 6-bit channels, three zero bits below each component
function automatic rgb_t model_expand(input dot_item_t it);
    rgb_t       px;
    pal_entry_t e;
    e = model_pal[it.pal_idx];
    if (it.is_direct) begin
        px.r = {it.direct[4:2], 3'b000};
        px.g = {it.direct[7:5], 3'b000};
        px.b = {it.direct[1:0], it.direct[1], 3'b000};
    end else begin
        px.r = {e[8:6], 3'b000};
        px.g = {e[5:3], 3'b000};
        px.b = {e[2:0], 3'b000};
    end
    return px;
endfunction

`endif

// File: sim/tb_vdp_color.sv
// testbench for the vdp color output stage
// random dots in every mode against a reference model, random
// output stalls, credit loop and pixel order checks
`timescale 1ns/100ps
`default_nettype none

module tb_vdp_color import vdp_color_pkg::*; ();

    localparam int FIFO_DEPTH      = 4;
    localparam int TOTAL_DOTS      = 1700;
    localparam int WATCHDOG_CYCLES = TOTAL_DOTS * 20 + 1000;

    logic          CLK21M;
    logic          RESET;
    display_mode_t mode;
    logic          reg_disp_on;
    logic          reg_col0_on;
    grb8_t         reg_frame_col;
    logic          pal_we;
    pal_idx_t      pal_addr;
    pal_entry_t    pal_data;
    logic          dot_valid;
    logic          dot_ready;
    dot_in_t       dot;
    logic          pix_valid;
    rgb_t          pix_rgb;
    logic          pix_ready;

    // expected pixels in dot order
    rgb_t exp_q [$];
    // cycle model of credits, fifo fill and output register
    int   m_credits;
    int   m_fifo_cnt;
    logic m_push;
    logic m_ret;
    logic m_out_full;

    `include "vdp_color_model.svh"

    vdp_color_top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (.*);

    initial begin
        CLK21M = 1'b0;
        forever #4 CLK21M = ~CLK21M;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // falling edge sampling, everything holds until the next rising edge
    always @(negedge CLK21M) begin
        logic acc;
        logic pop_m;
        if (RESET) begin
            m_credits  = FIFO_DEPTH;
            m_fifo_cnt = 0;
            m_push     = 1'b0;
            m_ret      = 1'b0;
            m_out_full = 1'b0;
        end else begin
            check_val("dot_ready", 32'(dot_ready), 32'(m_credits != 0));
            check_val("pix_valid", 32'(pix_valid), 32'(m_out_full));
            acc = dot_valid && dot_ready;
            if (acc) begin
                exp_q.push_back(model_expand(model_resolve(mode, reg_disp_on, reg_col0_on,
                                                           reg_frame_col, dot)));
            end
            if (pix_valid && pix_ready) begin
                if (exp_q.size() == 0) begin
                    $display("pixel delivered with no dot outstanding at %0t", $time);
                    $display("** FAIL **");
                    $fatal(1, "extra pixel");
                end else begin
                    check_val("pix_rgb", 32'(pix_rgb), 32'(exp_q.pop_front()));
                end
            end
            // pop when head present and output register free
            pop_m      = (m_fifo_cnt != 0) && (!m_out_full || pix_ready);
            m_credits  = m_credits - int'(acc) + int'(m_ret);
            m_fifo_cnt = m_fifo_cnt + int'(m_push) - int'(pop_m);
            m_out_full = pop_m || (m_out_full && !pix_ready);
            m_ret      = pop_m;
            m_push     = acc;
        end
    end

    task automatic write_pal(input pal_idx_t a, input pal_entry_t d);
        pal_we       = 1'b1;
        pal_addr     = a;
        pal_data     = d;
        model_pal[a] = d;
        @(posedge CLK21M);
        #1;
        pal_we = 1'b0;
    endtask

    task automatic set_regs(input display_mode_t m, input logic disp_on, input logic col0_on);
        mode          = m;
        reg_disp_on   = disp_on;
        reg_col0_on   = col0_on;
        reg_frame_col = grb8_t'($urandom);
    endtask

    // all dots delivered and every credit back
    task automatic wait_idle();
        while (exp_q.size() != 0 || m_credits != FIFO_DEPTH || m_out_full) begin
            @(posedge CLK21M);
            #1;
        end
    endtask

    // n accepted dots, pix_ready high on ready_pct percent of cycles
    task automatic run_dots(input int n, input int ready_pct);
        int   sent;
        logic took;
        sent = 0;
        while (sent < n) begin
            dot_valid        = ($urandom % 100) < 85;
            dot.pattern_code = grb8_t'($urandom);
            dot.sprite_code  = pal_idx_t'($urandom);
            dot.sprite_on    = ($urandom % 2) == 1;
            dot.window       = ($urandom % 8) != 0;
            pix_ready        = ($urandom % 100) < ready_pct;
            @(negedge CLK21M);
            took = dot_valid && dot_ready;
            @(posedge CLK21M);
            #1;
            if (took) begin
                sent++;
            end
        end
        dot_valid = 1'b0;
        pix_ready = 1'b1;
        wait_idle();
    endtask

    // half with col0 off, half with col0 on
    task automatic run_mode(input display_mode_t m);
        set_regs(m, 1'b1, 1'b0);
        run_dots(150, 100);
        set_regs(m, 1'b1, 1'b1);
        run_dots(150, 100);
    endtask

    initial begin
        void'($urandom(32'hbef8));
        RESET         = 1'b1;
        mode          = MODE_TEXT;
        reg_disp_on   = 1'b1;
        reg_col0_on   = 1'b0;
        reg_frame_col = '0;
        pal_we        = 1'b0;
        pal_addr      = '0;
        pal_data      = '0;
        dot_valid     = 1'b0;
        dot           = '0;
        pix_ready     = 1'b1;
        repeat (10) @(posedge CLK21M);
        #1;
        RESET = 1'b0;
        // idle outputs after reset
        @(negedge CLK21M);
        check_val("dot_ready", 32'(dot_ready), 32'd1);
        check_val("pix_valid", 32'(pix_valid), 32'd0);
        @(posedge CLK21M);
        #1;
        for (int i = 0; i < 16; i++) begin
            write_pal(pal_idx_t'(i), pal_entry_t'($urandom));
        end
        run_mode(MODE_TEXT);
        run_mode(MODE_GRAPHIC123);
        run_mode(MODE_GRAPHIC46);
        run_mode(MODE_GRAPHIC7);
        // output stalls, fifo fills and credits run out
        set_regs(MODE_GRAPHIC123, 1'b1, 1'b0);
        run_dots(150, 30);
        set_regs(MODE_GRAPHIC7, 1'b1, 1'b0);
        run_dots(150, 30);
        // display off, frame color only
        set_regs(MODE_GRAPHIC46, 1'b0, 1'b1);
        run_dots(100, 70);
        set_regs(MODE_GRAPHIC7, 1'b0, 1'b0);
        run_dots(100, 70);
        $display("** PASS **");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK21M);
        $display("watchdog expired, the dot stream stopped moving");
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: vdp_color.f
+incdir+sim
rtl/vdp_color_pkg.sv
rtl/vdp_dot_resolve.sv
rtl/vdp_dot_fifo.sv
rtl/vdp_color_out.sv
rtl/vdp_color_top.sv
sim/tb_vdp_color.sv
